//--- Makefile
# Verilator build and run of the sub_mult_abs testbench

VERILATOR ?= verilator
TB_TOP    ?= tb_sub_mult_abs
FILELIST  ?= sub_mult_abs.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TB_TOP), check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@if ! grep -q "Simulation passed" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@echo "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- abs_saturate.sv
`timescale 1ns/100ps

`include "sub_mult_abs_params.svh"

module abs_saturate (
  input  logic                           clk,
  input  logic                           reset,
  input  sub_mult_abs_pkg::signed_rslt_t s_data,
  input  logic                           s_valid,
  output logic                           s_ready,
  output sub_mult_abs_pkg::result_t      m_data,
  output logic                           m_valid,
  input  logic                           m_ready
);

  import sub_mult_abs_pkg::*;

  logic [`SMA_RSLT_W:0]   mag;
  logic [`SMA_RSLT_W-1:0] clamped;
  result_t                out_data;
  logic                   out_valid;
  logic                   out_free;

  // Two's complement negate, most negative input lands on the top bit
  assign mag = s_data.data[`SMA_RSLT_W] ? (~s_data.data + 1'b1) : s_data.data;

  // Anything past the unsigned range becomes full scale
  assign clamped = mag[`SMA_RSLT_W] ? '1 : mag[`SMA_RSLT_W-1:0];

  assign out_free = m_ready | ~out_valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (out_free) begin
      out_valid <= s_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (out_free) begin
      out_data.data <= clamped;
      out_data.last <= s_data.last;
    end
  end

  assign s_ready = out_free;
  assign m_data  = out_data;
  assign m_valid = out_valid;

endmodule

//--- axis_skid_buffer.sv
`timescale 1ns/100ps

module axis_skid_buffer #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  payload_t s_data,
  input  logic     s_valid,
  output logic     s_ready,
  output payload_t m_data,
  output logic     m_valid,
  input  logic     m_ready
);

  payload_t main_data;
  payload_t skid_data;
  logic     main_valid;
  logic     skid_valid;
  logic     ready_q;
  logic     s_fire;
  logic     out_free;
  logic     main_valid_next;
  logic     skid_valid_next;

  assign s_fire   = s_valid & ready_q;
  // Output register can take a new beat this cycle
  assign out_free = m_ready | ~main_valid;

  always_comb begin
    main_valid_next = main_valid;
    skid_valid_next = skid_valid;
    if (out_free) begin
      // Skid entry drains first, input is blocked while it is full
      main_valid_next = skid_valid | s_fire;
      skid_valid_next = 1'b0;
    end else if (s_fire) begin
      // Output stalled, park the beat in the skid entry
      skid_valid_next = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
      ready_q    <= 1'b0;
    end else begin
      main_valid <= main_valid_next;
      skid_valid <= skid_valid_next;
      ready_q    <= ~skid_valid_next;
    end
  end

  always_ff @(posedge clk) begin
    if (out_free) begin
      main_data <= skid_valid ? skid_data : s_data;
    end
    if (!out_free && s_fire) begin
      skid_data <= s_data;
    end
  end

  assign s_ready = ready_q;
  assign m_data  = main_data;
  assign m_valid = main_valid;

endmodule

//--- stream_join.sv
`timescale 1ns/100ps

module stream_join (
  input  logic                       clk,
  input  logic                       reset,
  input  sub_mult_abs_pkg::sample_t  x_data,
  input  logic                       x_valid,
  output logic                       x_ready,
  input  sub_mult_abs_pkg::sample_t  grid_data,
  input  logic                       grid_valid,
  output logic                       grid_ready,
  input  sub_mult_abs_pkg::scale_t   scale_data,
  input  logic                       scale_valid,
  output logic                       scale_ready,
  output sub_mult_abs_pkg::operand_t m_data,
  output logic                       m_valid,
  input  logic                       m_ready
);

  import sub_mult_abs_pkg::*;

  logic    x_done;
  logic    grid_done;
  logic    scale_done;
  sample_t x_hold;
  sample_t grid_hold;
  scale_t  scale_hold;
  sample_t x_cur;
  sample_t grid_cur;
  scale_t  scale_cur;
  logic    x_end;
  logic    grid_end;
  logic    scale_end;
  logic    frame_last;
  logic    fire;

  // A finished stream repeats its final sample
  assign x_cur     = x_done ? x_hold : x_data;
  assign grid_cur  = grid_done ? grid_hold : grid_data;
  assign scale_cur = scale_done ? scale_hold : scale_data;

  // Stream is done or presenting its last beat
  assign x_end     = x_done | x_data.last;
  assign grid_end  = grid_done | grid_data.last;
  assign scale_end = scale_done | scale_data.last;

  assign frame_last = x_end & grid_end & scale_end;

  // Only streams still inside the frame must present data
  assign m_valid = (x_done | x_valid) & (grid_done | grid_valid) &
                   (scale_done | scale_valid);
  assign fire    = m_valid & m_ready;

  // Done streams are not popped until the frame closes
  assign x_ready     = fire & ~x_done;
  assign grid_ready  = fire & ~grid_done;
  assign scale_ready = fire & ~scale_done;

  assign m_data.x     = x_cur.data;
  assign m_data.grid  = grid_cur.data;
  assign m_data.scale = scale_cur.data;
  assign m_data.last  = frame_last;

  always_ff @(posedge clk) begin
    if (reset) begin
      x_done     <= 1'b0;
      grid_done  <= 1'b0;
      scale_done <= 1'b0;
    end else if (fire) begin
      if (frame_last) begin
        // Frame closes for all three streams
        x_done     <= 1'b0;
        grid_done  <= 1'b0;
        scale_done <= 1'b0;
      end else begin
        x_done     <= x_done | x_data.last;
        grid_done  <= grid_done | grid_data.last;
        scale_done <= scale_done | scale_data.last;
      end
    end
  end

  // Keep the most recently popped beat of each stream
  always_ff @(posedge clk) begin
    if (x_ready) begin
      x_hold <= x_data;
    end
    if (grid_ready) begin
      grid_hold <= grid_data;
    end
    if (scale_ready) begin
      scale_hold <= scale_data;
    end
  end

endmodule

//--- sub_mult.sv
`timescale 1ns/100ps

`include "sub_mult_abs_params.svh"

module sub_mult (
  input  logic                           clk,
  input  logic                           reset,
  input  sub_mult_abs_pkg::operand_t     s_data,
  input  logic                           s_valid,
  output logic                           s_ready,
  output sub_mult_abs_pkg::signed_rslt_t m_data,
  output logic                           m_valid,
  input  logic                           m_ready
);

  import sub_mult_abs_pkg::*;

  localparam int DIFF_W = `SMA_DATA_W + 1;
  localparam int PROD_W = DIFF_W + `SMA_SCALE_W;
  localparam int OUT_W  = `SMA_RSLT_W + 1;
  localparam int SHIFT  = `SMA_DATA_FRAC + `SMA_SCALE_FRAC - `SMA_RSLT_FRAC;

  logic signed [DIFF_W-1:0]       diff;
  logic signed [DIFF_W-1:0]       s1_diff;
  logic signed [`SMA_SCALE_W-1:0] s1_scale;
  logic                           s1_last;
  logic                           s1_valid;
  logic                           s1_free;
  logic signed [PROD_W-1:0]       product;
  logic signed [PROD_W-1:0]       shifted;
  logic [PROD_W-OUT_W:0]          guard_bits;
  logic signed [OUT_W-1:0]        sat;
  signed_rslt_t                   s2_data;
  logic                           s2_valid;
  logic                           s2_free;

  // Extra bit keeps the difference exact
  assign diff = s_data.x - s_data.grid;

  assign product = s1_diff * s1_scale;
  // Arithmetic shift truncates toward minus infinity
  assign shifted = product >>> SHIFT;

  // Bits above the result sign must all match it, else overflow
  assign guard_bits = shifted[PROD_W-1:OUT_W-1];

  always_comb begin
    if (guard_bits == '0 || guard_bits == '1) begin
      sat = shifted[OUT_W-1:0];
    end else if (shifted[PROD_W-1]) begin
      sat = {1'b1, {(OUT_W-1){1'b0}}};
    end else begin
      sat = {1'b0, {(OUT_W-1){1'b1}}};
    end
  end

  assign s2_free = m_ready | ~s2_valid;
  assign s1_free = s2_free | ~s1_valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      if (s1_free) begin
        s1_valid <= s_valid;
      end
      if (s2_free) begin
        s2_valid <= s1_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s1_free) begin
      s1_diff  <= diff;
      s1_scale <= s_data.scale;
      s1_last  <= s_data.last;
    end
    if (s2_free) begin
      s2_data.data <= sat;
      s2_data.last <= s1_last;
    end
  end

  assign s_ready = s1_free;
  assign m_data  = s2_data;
  assign m_valid = s2_valid;

endmodule

//--- sub_mult_abs.f
+incdir+.
sub_mult_abs_pkg.sv
axis_skid_buffer.sv
stream_join.sv
sub_mult.sv
abs_saturate.sv
sub_mult_abs.sv
tb_sub_mult_abs.sv

//--- sub_mult_abs.sv
`timescale 1ns/100ps

module sub_mult_abs (
  input  logic                      clk,
  input  logic                      reset,
  input  sub_mult_abs_pkg::sample_t s_x_data,
  input  logic                      s_x_valid,
  output logic                      s_x_ready,
  input  sub_mult_abs_pkg::sample_t s_grid_data,
  input  logic                      s_grid_valid,
  output logic                      s_grid_ready,
  input  sub_mult_abs_pkg::scale_t  s_scale_data,
  input  logic                      s_scale_valid,
  output logic                      s_scale_ready,
  output sub_mult_abs_pkg::result_t m_rslt_data,
  output logic                      m_rslt_valid,
  input  logic                      m_rslt_ready
);

  import sub_mult_abs_pkg::*;

  sample_t      x_data;
  logic         x_valid;
  logic         x_ready;
  sample_t      grid_data;
  logic         grid_valid;
  logic         grid_ready;
  scale_t       scale_data;
  logic         scale_valid;
  logic         scale_ready;
  operand_t     op_data;
  logic         op_valid;
  logic         op_ready;
  signed_rslt_t prod_data;
  logic         prod_valid;
  logic         prod_ready;
  result_t      mag_data;
  logic         mag_valid;
  logic         mag_ready;

  // Input register slices
  axis_skid_buffer #(.payload_t(sample_t)) x_buf_inst (
    .clk(clk), .reset(reset),
    .s_data(s_x_data), .s_valid(s_x_valid), .s_ready(s_x_ready),
    .m_data(x_data), .m_valid(x_valid), .m_ready(x_ready)
  );

  axis_skid_buffer #(.payload_t(sample_t)) grid_buf_inst (
    .clk(clk), .reset(reset),
    .s_data(s_grid_data), .s_valid(s_grid_valid), .s_ready(s_grid_ready),
    .m_data(grid_data), .m_valid(grid_valid), .m_ready(grid_ready)
  );

  axis_skid_buffer #(.payload_t(scale_t)) scale_buf_inst (
    .clk(clk), .reset(reset),
    .s_data(s_scale_data), .s_valid(s_scale_valid), .s_ready(s_scale_ready),
    .m_data(scale_data), .m_valid(scale_valid), .m_ready(scale_ready)
  );

  stream_join stream_join_inst (
    .clk(clk), .reset(reset),
    .x_data(x_data), .x_valid(x_valid), .x_ready(x_ready),
    .grid_data(grid_data), .grid_valid(grid_valid), .grid_ready(grid_ready),
    .scale_data(scale_data), .scale_valid(scale_valid), .scale_ready(scale_ready),
    .m_data(op_data), .m_valid(op_valid), .m_ready(op_ready)
  );

  sub_mult sub_mult_inst (
    .clk(clk), .reset(reset),
    .s_data(op_data), .s_valid(op_valid), .s_ready(op_ready),
    .m_data(prod_data), .m_valid(prod_valid), .m_ready(prod_ready)
  );

  abs_saturate abs_saturate_inst (
    .clk(clk), .reset(reset),
    .s_data(prod_data), .s_valid(prod_valid), .s_ready(prod_ready),
    .m_data(mag_data), .m_valid(mag_valid), .m_ready(mag_ready)
  );

  // Output slice decouples m_rslt_ready from the pipeline
  axis_skid_buffer #(.payload_t(result_t)) rslt_buf_inst (
    .clk(clk), .reset(reset),
    .s_data(mag_data), .s_valid(mag_valid), .s_ready(mag_ready),
    .m_data(m_rslt_data), .m_valid(m_rslt_valid), .m_ready(m_rslt_ready)
  );

endmodule

//--- sub_mult_abs_params.svh
`ifndef SUB_MULT_ABS_PARAMS_SVH
`define SUB_MULT_ABS_PARAMS_SVH

// Measurement x and reference grid, signed fixed point
`define SMA_DATA_W     16
`define SMA_DATA_FRAC  12

// Scale factor, signed fixed point
`define SMA_SCALE_W    16
`define SMA_SCALE_FRAC 12

// Output magnitude, unsigned fixed point
`define SMA_RSLT_W     16
`define SMA_RSLT_FRAC  12

// The product carries DATA_FRAC + SCALE_FRAC fractional bits and is
// shifted down to RSLT_FRAC before saturation

`endif

//--- sub_mult_abs_pkg.sv
`include "sub_mult_abs_params.svh"

package sub_mult_abs_pkg;

  // Beat of the x or grid input stream
  typedef struct packed {
    logic signed [`SMA_DATA_W-1:0] data;
    logic                          last;
  } sample_t;

  // Beat of the scale input stream
  typedef struct packed {
    logic signed [`SMA_SCALE_W-1:0] data;
    logic                           last;
  } scale_t;

  // Joined operands of one output beat
  typedef struct packed {
    logic signed [`SMA_DATA_W-1:0]  x;
    logic signed [`SMA_DATA_W-1:0]  grid;
    logic signed [`SMA_SCALE_W-1:0] scale;
    logic                           last;
  } operand_t;

  // Rescaled product, one extra bit so the sign survives saturation
  typedef struct packed {
    logic signed [`SMA_RSLT_W:0] data;
    logic                        last;
  } signed_rslt_t;

  // Final unsigned magnitude
  typedef struct packed {
    logic [`SMA_RSLT_W-1:0] data;
    logic                   last;
  } result_t;

endpackage

//--- tb_sub_mult_abs.sv
`timescale 1ns/100ps

module tb_sub_mult_abs;

  import sub_mult_abs_pkg::*;

  localparam int          N_IN    = 15;
  localparam int          N_OUT   = 17;
  localparam int          TIMEOUT = 1000;
  localparam logic [31:0] SEED    = 32'h6af5df21;

  // Rows are {data, last} with Q4.12 inputs and a Q4.12 unsigned result
  // Frames 1-2 basic and truncation, 3 saturation, 4 grid and scale short,
  // 5 x short, 6-8 single beats
  localparam logic [16:0] X_TAB [N_IN] = '{
    {16'h1000, 1'b0}, {16'h0400, 1'b1}, {16'h0003, 1'b0}, {16'h0000, 1'b1},
    {16'h7fff, 1'b0}, {16'h8000, 1'b0}, {16'h8000, 1'b0}, {16'h7fff, 1'b1},
    {16'h1000, 1'b0}, {16'h2000, 1'b0}, {16'h3000, 1'b1}, {16'h0000, 1'b1},
    {16'h0100, 1'b1}, {16'h0000, 1'b1}, {16'hffff, 1'b1}
  };
  localparam logic [16:0] GRID_TAB [N_IN] = '{
    {16'h0800, 1'b0}, {16'h0c00, 1'b1}, {16'h0000, 1'b0}, {16'h0003, 1'b1},
    {16'h8000, 1'b0}, {16'h7fff, 1'b0}, {16'h0000, 1'b0}, {16'h0000, 1'b1},
    {16'h0800, 1'b1}, {16'h1000, 1'b0}, {16'h2000, 1'b0}, {16'hf000, 1'b1},
    {16'h0000, 1'b1}, {16'h0200, 1'b1}, {16'h0000, 1'b1}
  };
  localparam logic [16:0] SCALE_TAB [N_IN] = '{
    {16'h2000, 1'b0}, {16'h1000, 1'b1}, {16'h0800, 1'b0}, {16'h0800, 1'b1},
    {16'h7fff, 1'b0}, {16'h7fff, 1'b0}, {16'h2000, 1'b0}, {16'h2000, 1'b1},
    {16'h1000, 1'b0}, {16'h0800, 1'b1}, {16'h1000, 1'b0}, {16'h3000, 1'b1},
    {16'h1000, 1'b1}, {16'he000, 1'b1}, {16'h0001, 1'b1}
  };
  // Magnitude of floor((x - grid) * scale / 4096) clamped to 16'hffff
  localparam logic [16:0] EXP_TAB [N_OUT] = '{
    {16'h1000, 1'b0}, {16'h0800, 1'b1}, {16'h0001, 1'b0}, {16'h0002, 1'b1},
    {16'hffff, 1'b0}, {16'hffff, 1'b0}, {16'hffff, 1'b0}, {16'hfffe, 1'b1},
    {16'h0800, 1'b0}, {16'h0c00, 1'b0}, {16'h1400, 1'b1},
    {16'h1000, 1'b0}, {16'h6000, 1'b0}, {16'h3000, 1'b1},
    {16'h0100, 1'b1}, {16'h0400, 1'b1}, {16'h0001, 1'b1}
  };

  logic    clk;
  logic    reset;
  sample_t s_x_data;
  logic    s_x_valid;
  logic    s_x_ready;
  sample_t s_grid_data;
  logic    s_grid_valid;
  logic    s_grid_ready;
  scale_t  s_scale_data;
  logic    s_scale_valid;
  logic    s_scale_ready;
  result_t m_rslt_data;
  logic    m_rslt_valid;
  logic    m_rslt_ready;

  sub_mult_abs sub_mult_abs_inst (
    .clk(clk), .reset(reset),
    .s_x_data(s_x_data), .s_x_valid(s_x_valid), .s_x_ready(s_x_ready),
    .s_grid_data(s_grid_data), .s_grid_valid(s_grid_valid), .s_grid_ready(s_grid_ready),
    .s_scale_data(s_scale_data), .s_scale_valid(s_scale_valid),
    .s_scale_ready(s_scale_ready),
    .m_rslt_data(m_rslt_data), .m_rslt_valid(m_rslt_valid), .m_rslt_ready(m_rslt_ready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic report_failure(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1);
  endtask

  // Active on about three cycles in four
  function automatic logic send_now();
    return ($urandom % 4) != 0;
  endfunction

  initial begin : x_source
    int idx;
    int stall;
    idx = 0;
    stall = 0;
    while (idx < N_IN) begin
      @(posedge clk);
      if (s_x_valid && s_x_ready)
        idx++;
      stall = (s_x_valid && !s_x_ready) ? stall + 1 : 0;
      assert (stall < TIMEOUT) else report_failure("x input was never accepted");
      // Hold the beat until it is taken
      if (!reset && (!s_x_valid || s_x_ready)) begin
        s_x_valid <= (idx < N_IN) && send_now();
        s_x_data  <= X_TAB[idx % N_IN];
      end
    end
  end

  initial begin : grid_source
    int idx;
    int stall;
    idx = 0;
    stall = 0;
    while (idx < N_IN) begin
      @(posedge clk);
      if (s_grid_valid && s_grid_ready)
        idx++;
      stall = (s_grid_valid && !s_grid_ready) ? stall + 1 : 0;
      assert (stall < TIMEOUT) else report_failure("grid input was never accepted");
      if (!reset && (!s_grid_valid || s_grid_ready)) begin
        s_grid_valid <= (idx < N_IN) && send_now();
        s_grid_data  <= GRID_TAB[idx % N_IN];
      end
    end
  end

  initial begin : scale_source
    int idx;
    int stall;
    idx = 0;
    stall = 0;
    while (idx < N_IN) begin
      @(posedge clk);
      if (s_scale_valid && s_scale_ready)
        idx++;
      stall = (s_scale_valid && !s_scale_ready) ? stall + 1 : 0;
      assert (stall < TIMEOUT) else report_failure("scale input was never accepted");
      if (!reset && (!s_scale_valid || s_scale_ready)) begin
        s_scale_valid <= (idx < N_IN) && send_now();
        s_scale_data  <= SCALE_TAB[idx % N_IN];
      end
    end
  end

  initial begin : run
    int n;
    int idle;
    void'($urandom(SEED));
    reset         = 1'b1;
    s_x_data      = '0;
    s_x_valid     = 1'b0;
    s_grid_data   = '0;
    s_grid_valid  = 1'b0;
    s_scale_data  = '0;
    s_scale_valid = 1'b0;
    m_rslt_ready  = 1'b0;

    // Output valid sampled mid-cycle through reset and one cycle after
    @(posedge clk);
    @(negedge clk);
    assert (!m_rslt_valid) else report_failure("m_rslt_valid high during reset");
    @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    assert (!m_rslt_valid) else
      report_failure("m_rslt_valid high on the first cycle after reset");
    @(posedge clk);
    @(negedge clk);
    assert (!m_rslt_valid) else
      report_failure("m_rslt_valid high on the second cycle after reset");

    n = 0;
    idle = 0;
    while (n < N_OUT) begin
      @(posedge clk);
      if (m_rslt_valid && m_rslt_ready) begin
        assert (m_rslt_data.data == EXP_TAB[n][16:1]) else
          report_failure($sformatf("MISMATCH at %0t: m_rslt_data.data beat %0d got %h expected %h",
                                   $time, n, m_rslt_data.data, EXP_TAB[n][16:1]));
        assert (m_rslt_data.last == EXP_TAB[n][0]) else
          report_failure($sformatf("MISMATCH at %0t: m_rslt_data.last beat %0d got %b expected %b",
                                   $time, n, m_rslt_data.last, EXP_TAB[n][0]));
        n++;
        idle = 0;
      end else begin
        idle++;
        assert (idle < TIMEOUT) else report_failure("no output beat arrived within the timeout");
      end
      m_rslt_ready <= send_now();
    end

    // Nothing may follow the final beat
    m_rslt_ready <= 1'b1;
    repeat (10) begin
      @(posedge clk);
      assert (!m_rslt_valid) else report_failure("extra output beat after the expected frames");
    end
    $display("Simulation passed");
    $finish;
  end

endmodule
